//--- Makefile
# Verilator build and run of the Tomasulo core testbench.

TOP := tb_tomasulo

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Test failed" sim.log; then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Test passed" sim.log; then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf obj_dir sim.log

//--- dv/tb_tomasulo.sv
// Testbench for the Tomasulo core with directed and random programs and a reference model.
`timescale 1ns/1ps
`default_nettype none

module tb_tomasulo;

    logic                                  clk;
    logic                                  rst1;
    logic                                  issue_valid;
    tomasulo_pkg::instr_t                  issue_instr;
    logic                                  issue_stall;
    tomasulo_pkg::cdb_t                    cdb;
    tomasulo_pkg::reg_idx_t                rd_addr;
    tomasulo_pkg::data_t                   rd_data;
    tomasulo_pkg::cdb_t                    expect_out;
    logic                                  check_regs;
    tomasulo_pkg::data_t                   model_regs [tomasulo_pkg::NUM_REGS];
    logic [tomasulo_pkg::NUM_STATIONS-1:0] busy_mask;
    int                                    tb_errors;
    int                                    timeouts;
    int                                    issued;
    int                                    stall_cycles;
    int                                    mon_errors;
    int                                    pulses;

    tomasulo_core i_tomasulo_core (
        .clk         (clk),
        .rst1        (rst1),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .issue_stall (issue_stall),
        .cdb         (cdb),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

    tomasulo_monitor i_monitor (
        .clk         (clk),
        .rst1        (rst1),
        .cdb         (cdb),
        .expect_in   (expect_out),
        .check_regs  (check_regs),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .model_regs  (model_regs),
        .error_count (mon_errors),
        .pulse_count (pulses)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ************************************************************
    // Reference model
    // ************************************************************

    function automatic tomasulo_pkg::data_t ref_result(tomasulo_pkg::instr_t ins);
        tomasulo_pkg::data_t a;
        tomasulo_pkg::data_t b;
        a = model_regs[ins.rs1];
        b = model_regs[ins.rs2];
        case (ins.op)
            tomasulo_pkg::OP_ADD:   return a + b;
            tomasulo_pkg::OP_SUB:   return a - b;
            tomasulo_pkg::OP_AND:   return a & b;
            tomasulo_pkg::OP_XOR:   return a ^ b;
            tomasulo_pkg::OP_LOADI: return {8'h00, ins.imm};
            default:                return '0;
        endcase
    endfunction

    // Stations are handed out lowest number first.
    function automatic tomasulo_pkg::tag_t lowest_free(
        logic [tomasulo_pkg::NUM_STATIONS-1:0] mask);
        for (int i = 0; i < tomasulo_pkg::NUM_STATIONS; i++) begin
            if (!mask[i]) begin
                return tomasulo_pkg::tag_t'(i);
            end
        end
        return '0;
    endfunction

    function automatic tomasulo_pkg::instr_t make_instr(tomasulo_pkg::op_e op,
                                                        int rd, int rs1, int rs2, int imm);
        tomasulo_pkg::instr_t res;
        res.op  = op;
        res.rd  = tomasulo_pkg::reg_idx_t'(rd);
        res.rs1 = tomasulo_pkg::reg_idx_t'(rs1);
        res.rs2 = tomasulo_pkg::reg_idx_t'(rs2);
        res.imm = tomasulo_pkg::imm_t'(imm);
        return res;
    endfunction

    function automatic tomasulo_pkg::instr_t random_instr();
        tomasulo_pkg::op_e op;
        op = tomasulo_pkg::op_e'(3'($urandom_range(4, 0)));
        return make_instr(op, int'($urandom_range(7, 0)), int'($urandom_range(7, 0)),
                          int'($urandom_range(7, 0)), int'($urandom_range(255, 0)));
    endfunction

    task automatic end_run();
        $display("Summary: %0d testbench errors, %0d monitor errors, %0d timeouts, %0d issued",
                 tb_errors, mon_errors, timeouts, issued);
        if (tb_errors + mon_errors + timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    // ************************************************************
    // Cycle driver
    // ************************************************************

    // Drive inputs on one falling edge and track acceptance and station use.
    task automatic tick(input logic valid, input tomasulo_pkg::instr_t ins, output logic acc);
        tomasulo_pkg::tag_t tag;
        @(negedge clk);
        issue_valid = valid;
        issue_instr = ins;
        expect_out  = '0;
        if (issue_stall !== (&busy_mask)) begin
            tb_errors++;
            $display("FAIL issue_stall: got %h, expected %h", issue_stall, &busy_mask);
        end
        if (issue_stall) begin
            stall_cycles++;
        end
        acc = valid && !issue_stall;
        if (acc) begin
            tag                = lowest_free(busy_mask);
            busy_mask[tag]     = 1'b1;
            expect_out.valid   = 1'b1;
            expect_out.tag     = tag;
            expect_out.value   = ref_result(ins);
            model_regs[ins.rd] = expect_out.value;
            issued++;
        end
        // Station of a broadcast is free from the next edge.
        if (cdb.valid) begin
            busy_mask[cdb.tag] = 1'b0;
        end
    endtask

    task automatic issue(input tomasulo_pkg::instr_t ins);
        logic acc;
        int   waited;
        acc    = 1'b0;
        waited = 0;
        while (!acc && waited < 100) begin
            tick(1'b1, ins, acc);
            waited++;
        end
        if (!acc) begin
            timeouts++;
            $display("Timeout: instruction still held by issue_stall after 100 cycles");
            end_run();
        end
    endtask

    task automatic idle(input int n);
        logic acc;
        repeat (n) tick(1'b0, '0, acc);
    endtask

    task automatic drain();
        logic acc;
        int   waited;
        waited = 0;
        while (busy_mask != '0 && waited < 200) begin
            tick(1'b0, '0, acc);
            waited++;
        end
        if (busy_mask != '0) begin
            timeouts++;
            $display("Timeout: stations did not drain within 200 cycles");
            end_run();
        end else begin
            tick(1'b0, '0, acc);
        end
    endtask

    task automatic read_back();
        logic acc;
        for (int r = 0; r < tomasulo_pkg::NUM_REGS; r++) begin
            tick(1'b0, '0, acc);
            rd_addr    = tomasulo_pkg::reg_idx_t'(r);
            check_regs = 1'b1;
        end
        tick(1'b0, '0, acc);
        check_regs = 1'b0;
    endtask

    // ************************************************************
    // Programs
    // ************************************************************

    initial begin
        void'($urandom(74));
        rst1         = 1'b0;
        issue_valid  = 1'b0;
        issue_instr  = '0;
        rd_addr      = '0;
        check_regs   = 1'b0;
        expect_out   = '0;
        busy_mask    = '0;
        tb_errors    = 0;
        timeouts     = 0;
        issued       = 0;
        stall_cycles = 0;
        for (int r = 0; r < tomasulo_pkg::NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst1 = 1'b1;
        read_back();

        // Independent operations on loaded registers.
        issue(make_instr(tomasulo_pkg::OP_LOADI, 1, 0, 0, 8'h3c));
        issue(make_instr(tomasulo_pkg::OP_LOADI, 2, 0, 0, 8'h15));
        issue(make_instr(tomasulo_pkg::OP_LOADI, 3, 0, 0, 8'ha5));
        issue(make_instr(tomasulo_pkg::OP_LOADI, 4, 0, 0, 8'h5a));
        issue(make_instr(tomasulo_pkg::OP_ADD, 5, 1, 2, 0));
        issue(make_instr(tomasulo_pkg::OP_SUB, 6, 2, 1, 0));
        issue(make_instr(tomasulo_pkg::OP_AND, 7, 3, 4, 0));
        issue(make_instr(tomasulo_pkg::OP_XOR, 0, 3, 4, 0));
        drain();
        read_back();

        // Chains with gaps that put the producer on the CDB at issue.
        for (int gap = 0; gap < 4; gap++) begin
            issue(make_instr(tomasulo_pkg::OP_LOADI, 1, 0, 0, 8'h10 + gap));
            idle(gap);
            issue(make_instr(tomasulo_pkg::OP_ADD, 2, 1, 1, 0));
            issue(make_instr(tomasulo_pkg::OP_SUB, 3, 2, 1, 0));
        end
        drain();
        read_back();

        // Older add on r3 finishes after the younger loadi.
        issue(make_instr(tomasulo_pkg::OP_LOADI, 1, 0, 0, 8'h07));
        issue(make_instr(tomasulo_pkg::OP_ADD, 3, 1, 1, 0));
        issue(make_instr(tomasulo_pkg::OP_LOADI, 3, 0, 0, 8'h99));
        drain();
        read_back();

        stall_cycles = 0;
        issue(make_instr(tomasulo_pkg::OP_LOADI, 1, 0, 0, 8'h01));
        repeat (16) issue(make_instr(tomasulo_pkg::OP_ADD, 1, 1, 1, 0));
        drain();
        read_back();
        if (stall_cycles == 0) begin
            tb_errors++;
            $display("issue_stall never rose while a long chain filled the stations");
        end

        repeat (300) begin
            if ($urandom_range(3, 0) == 0) begin
                idle(int'($urandom_range(3, 1)));
            end
            issue(random_instr());
        end
        drain();
        read_back();

        if (pulses != issued) begin
            tb_errors++;
            $display("FAIL cdb pulse count: got %h, expected %h", pulses, issued);
        end
        end_run();
    end

endmodule

`default_nettype wire

//--- dv/tomasulo_checker.sv
// Bound assertions on issue acceptance and CDB rules of the Tomasulo core.
`timescale 1ns/1ps
`default_nettype none

module tomasulo_checker (
    input wire logic                                  clk,
    input wire logic                                  rst1,
    input wire logic [tomasulo_pkg::NUM_STATIONS-1:0] load_en,
    input wire tomasulo_pkg::cdb_t                    cdb,
    input wire tomasulo_pkg::ctl_word                 stations [tomasulo_pkg::NUM_STATIONS]
);

    logic [tomasulo_pkg::NUM_STATIONS-1:0] busy_vec;

    always_comb begin
        for (int i = 0; i < tomasulo_pkg::NUM_STATIONS; i++) begin
            busy_vec[i] = stations[i].busy;
        end
    end

    // A load goes to one free station only, so a full bank takes none.
    load_only_free_station: assert property (@(posedge clk) disable iff (!rst1)
        $onehot0(load_en) && ((load_en & busy_vec) == '0))
        else $error("Station load strobe to a busy station or to several stations");

    cdb_quiet_after_reset: assert property (@(posedge clk)
        !rst1 |=> !cdb.valid)
        else $error("CDB pulse in the cycle after reset");

    // The broadcasting station stays busy through its CDB cycle.
    cdb_tag_is_busy: assert property (@(posedge clk) disable iff (!rst1)
        cdb.valid |-> stations[cdb.tag].busy)
        else $error("CDB tag names a station that is not busy");

endmodule

bind tomasulo_core tomasulo_checker i_checker (
    .clk         (clk),
    .rst1        (rst1),
    .load_en     (load_en),
    .cdb         (cdb),
    .stations    (stations)
);

`default_nettype wire

//--- dv/tomasulo_monitor.sv
// Monitor that checks CDB results by tag and the register file through the read port.
`timescale 1ns/1ps
`default_nettype none

module tomasulo_monitor (
    input  wire logic                   clk,
    input  wire logic                   rst1,
    input  wire tomasulo_pkg::cdb_t     cdb,
    input  wire tomasulo_pkg::cdb_t     expect_in,
    input  wire logic                   check_regs,
    input  wire tomasulo_pkg::reg_idx_t rd_addr,
    input  wire tomasulo_pkg::data_t    rd_data,
    input  wire tomasulo_pkg::data_t    model_regs [tomasulo_pkg::NUM_REGS],
    output int                          error_count,
    output int                          pulse_count
);

    tomasulo_pkg::cdb_t pending [$];
    int                 errors = 0;
    int                 pulses = 0;

    assign error_count = errors;
    assign pulse_count = pulses;

    // Expectations and read-back at the rising edge, CDB at the falling edge.
    initial begin
        int   idx;
        logic found;
        forever begin
            @(posedge clk);
            if (expect_in.valid) begin
                pending.push_back(expect_in);
            end
            if (check_regs && rd_data !== model_regs[rd_addr]) begin
                errors++;
                $display("FAIL rd_data[r%0d]: got %h, expected %h",
                         rd_addr, rd_data, model_regs[rd_addr]);
            end
            @(negedge clk);
            if (rst1 && cdb.valid) begin
                pulses++;
                found = 1'b0;
                idx   = 0;
                for (int i = 0; i < pending.size(); i++) begin
                    if (!found && pending[i].tag == cdb.tag) begin
                        found = 1'b1;
                        idx   = i;
                    end
                end
                if (!found) begin
                    errors++;
                    $display("CDB pulse on tag %0d with no instruction waiting for it",
                             cdb.tag);
                end else begin
                    if (cdb.value !== pending[idx].value) begin
                        errors++;
                        $display("FAIL cdb.value (tag %0d): got %h, expected %h",
                                 cdb.tag, cdb.value, pending[idx].value);
                    end
                    pending.delete(idx);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/ctl_word_bank.sv
// Reservation-station store of eight control words with per-station load, clear and CDB capture.
`timescale 1ns/1ps
`default_nettype none

module ctl_word_bank (
    input  wire logic                                  clk,
    input  wire logic                                  rst1,
    input  wire logic [tomasulo_pkg::NUM_STATIONS-1:0] load_en,
    input  wire tomasulo_pkg::ctl_word                 load_word,
    input  wire logic [tomasulo_pkg::NUM_STATIONS-1:0] dispatch_en,
    input  wire tomasulo_pkg::cdb_t                    cdb,
    output tomasulo_pkg::ctl_word                      stations [tomasulo_pkg::NUM_STATIONS]
);

    // ************************************************************
    // Station registers
    // ************************************************************

    // Each station has its own enable and its own clear.
    // A load and a clear never meet, since issue only picks free stations
    // and a station is still busy during its own CDB cycle.
    always_ff @(posedge clk) begin
        if (!rst1) begin
            for (int i = 0; i < tomasulo_pkg::NUM_STATIONS; i++) begin
                stations[i].busy   <= 1'b0;
                stations[i].issued <= 1'b0;
            end
        end else begin
            for (int i = 0; i < tomasulo_pkg::NUM_STATIONS; i++) begin
                if (cdb.valid && cdb.tag == tomasulo_pkg::tag_t'(i)) begin
                    // Result broadcast releases the station.
                    stations[i].busy   <= 1'b0;
                    stations[i].issued <= 1'b0;
                end else if (load_en[i]) begin
                    stations[i] <= load_word;
                end else begin
                    if (dispatch_en[i]) begin
                        stations[i].issued <= 1'b1;
                    end
                    // Waiting sources watch the bus.
                    stations[i].src1 <= tomasulo_pkg::snoop(stations[i].src1, cdb);
                    stations[i].src2 <= tomasulo_pkg::snoop(stations[i].src2, cdb);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/exec_pipe.sv
// Dispatch of the lowest ready station into a two-stage integer ALU that drives the CDB.
`timescale 1ns/1ps
`default_nettype none

module exec_pipe (
    input  wire logic                             clk,
    input  wire logic                             rst1,
    input  wire tomasulo_pkg::ctl_word            stations [tomasulo_pkg::NUM_STATIONS],
    output logic [tomasulo_pkg::NUM_STATIONS-1:0] dispatch_en,
    output tomasulo_pkg::cdb_t                    cdb
);

    typedef struct packed {
        logic                valid;
        tomasulo_pkg::op_e   op;
        tomasulo_pkg::tag_t  tag;
        tomasulo_pkg::data_t a;
        tomasulo_pkg::data_t b;
    } alu_req_t;

    logic [tomasulo_pkg::NUM_STATIONS-1:0] eligible;
    logic                                  found;
    tomasulo_pkg::tag_t                    sel;
    alu_req_t                              s1;
    tomasulo_pkg::data_t                   result;
    tomasulo_pkg::cdb_t                    cdb_q;

    // ************************************************************
    // Selection
    // ************************************************************

    always_comb begin
        for (int i = 0; i < tomasulo_pkg::NUM_STATIONS; i++) begin
            eligible[i] = stations[i].busy && !stations[i].issued &&
                          stations[i].src1.ready && stations[i].src2.ready;
        end
    end

    always_comb begin
        dispatch_en = '0;
        found       = 1'b0;
        sel         = '0;
        for (int i = 0; i < tomasulo_pkg::NUM_STATIONS; i++) begin
            if (!found && eligible[i]) begin
                dispatch_en[i] = 1'b1;
                found          = 1'b1;
                sel            = tomasulo_pkg::tag_t'(i);
            end
        end
    end

    // ************************************************************
    // ALU stages
    // ************************************************************

    always_comb begin
        case (s1.op)
            tomasulo_pkg::OP_ADD:   result = s1.a + s1.b;
            tomasulo_pkg::OP_SUB:   result = s1.a - s1.b;
            tomasulo_pkg::OP_AND:   result = s1.a & s1.b;
            tomasulo_pkg::OP_XOR:   result = s1.a ^ s1.b;
            tomasulo_pkg::OP_LOADI: result = s1.a;
            default:                result = '0;
        endcase
    end

    // Stage one latches operands, stage two latches the result onto the bus.
    always_ff @(posedge clk) begin
        if (!rst1) begin
            s1.valid    <= 1'b0;
            cdb_q.valid <= 1'b0;
        end else begin
            s1.valid    <= found;
            s1.op       <= stations[sel].op;
            s1.tag      <= sel;
            s1.a        <= stations[sel].src1.value;
            s1.b        <= stations[sel].src2.value;
            cdb_q.valid <= s1.valid;
            cdb_q.tag   <= s1.tag;
            cdb_q.value <= result;
        end
    end

    assign cdb = cdb_q;

endmodule

`default_nettype wire

//--- hdl/issue_ctl.sv
// Issue stage: free-station search, operand lookup with CDB bypass, station load and rename.
`timescale 1ns/1ps
`default_nettype none

module issue_ctl (
    input  wire logic                                  issue_valid,
    input  wire tomasulo_pkg::instr_t                  issue_instr,
    input  wire tomasulo_pkg::ctl_word                 stations [tomasulo_pkg::NUM_STATIONS],
    input  wire tomasulo_pkg::cdb_t                    cdb,
    input  wire tomasulo_pkg::operand_t                look1,
    input  wire tomasulo_pkg::operand_t                look2,
    output tomasulo_pkg::reg_idx_t                     look_rs1,
    output tomasulo_pkg::reg_idx_t                     look_rs2,
    output logic [tomasulo_pkg::NUM_STATIONS-1:0]      load_en,
    output tomasulo_pkg::ctl_word                      load_word,
    output logic                                       rename_en,
    output tomasulo_pkg::reg_idx_t                     rename_rd,
    output tomasulo_pkg::tag_t                         rename_tag,
    output logic                                       issue_stall
);

    logic                   have_free;
    tomasulo_pkg::tag_t     free_tag;
    logic                   accept;
    tomasulo_pkg::operand_t src1;
    tomasulo_pkg::operand_t src2;

    // Lowest-numbered free station.
    always_comb begin
        have_free = 1'b0;
        free_tag  = '0;
        for (int i = tomasulo_pkg::NUM_STATIONS - 1; i >= 0; i--) begin
            if (!stations[i].busy) begin
                have_free = 1'b1;
                free_tag  = tomasulo_pkg::tag_t'(i);
            end
        end
    end

    assign issue_stall = !have_free;
    assign accept      = issue_valid && have_free;

    assign look_rs1 = issue_instr.rs1;
    assign look_rs2 = issue_instr.rs2;

    // ************************************************************
    // Station word
    // ************************************************************

    always_comb begin
        if (issue_instr.op == tomasulo_pkg::OP_LOADI) begin
            src1.ready = 1'b1;
            src1.tag   = '0;
            src1.value = tomasulo_pkg::data_t'(issue_instr.imm);
            src2.ready = 1'b1;
            src2.tag   = '0;
            src2.value = '0;
        end else begin
            // Producer finishing this cycle counts as ready.
            src1 = tomasulo_pkg::snoop(look1, cdb);
            src2 = tomasulo_pkg::snoop(look2, cdb);
        end
    end

    always_comb begin
        load_word.busy   = 1'b1;
        load_word.issued = 1'b0;
        load_word.op     = issue_instr.op;
        load_word.src1   = src1;
        load_word.src2   = src2;
    end

    assign load_en = accept ? ({{(tomasulo_pkg::NUM_STATIONS - 1){1'b0}}, 1'b1} << free_tag)
                            : '0;

    // The station number becomes the rename tag of rd.
    assign rename_en  = accept;
    assign rename_rd  = issue_instr.rd;
    assign rename_tag = free_tag;

endmodule

`default_nettype wire

//--- hdl/reg_status.sv
// Architectural register file with busy/tag status, rename on issue and CDB writeback.
`timescale 1ns/1ps
`default_nettype none

module reg_status (
    input  wire logic                   clk,
    input  wire logic                   rst1,
    input  wire logic                   rename_en,
    input  wire tomasulo_pkg::reg_idx_t rename_rd,
    input  wire tomasulo_pkg::tag_t     rename_tag,
    input  wire tomasulo_pkg::cdb_t     cdb,
    input  wire tomasulo_pkg::reg_idx_t look_rs1,
    input  wire tomasulo_pkg::reg_idx_t look_rs2,
    output tomasulo_pkg::operand_t      look1,
    output tomasulo_pkg::operand_t      look2,
    input  wire tomasulo_pkg::reg_idx_t rd_addr,
    output tomasulo_pkg::data_t         rd_data
);

    tomasulo_pkg::data_t              regs [tomasulo_pkg::NUM_REGS];
    tomasulo_pkg::tag_t               tags [tomasulo_pkg::NUM_REGS];
    logic [tomasulo_pkg::NUM_REGS-1:0] busy;

    // Value when idle, producer tag when renamed.
    function automatic tomasulo_pkg::operand_t lookup(tomasulo_pkg::reg_idx_t r);
        tomasulo_pkg::operand_t res;
        res.ready = !busy[r];
        res.tag   = tags[r];
        res.value = regs[r];
        return res;
    endfunction

    always_comb begin
        look1 = lookup(look_rs1);
        look2 = lookup(look_rs2);
    end

    assign rd_data = regs[rd_addr];

    // ************************************************************
    // Rename and writeback
    // ************************************************************

    always_ff @(posedge clk) begin
        if (!rst1) begin
            for (int r = 0; r < tomasulo_pkg::NUM_REGS; r++) begin
                regs[r] <= '0;
            end
            busy <= '0;
        end else begin
            for (int r = 0; r < tomasulo_pkg::NUM_REGS; r++) begin
                if (rename_en && rename_rd == tomasulo_pkg::reg_idx_t'(r)) begin
                    // Newer producer takes over.
                    busy[r] <= 1'b1;
                    tags[r] <= rename_tag;
                end else if (cdb.valid && busy[r] && tags[r] == cdb.tag) begin
                    busy[r] <= 1'b0;
                    regs[r] <= cdb.value;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/tomasulo_core.sv
// Top of the Tomasulo execution core: station bank, register status, issue and execute.
`timescale 1ns/1ps
`default_nettype none

module tomasulo_core (
    input  wire logic                   clk,
    input  wire logic                   rst1,
    input  wire logic                   issue_valid,
    input  wire tomasulo_pkg::instr_t   issue_instr,
    output logic                        issue_stall,
    output tomasulo_pkg::cdb_t          cdb,
    input  wire tomasulo_pkg::reg_idx_t rd_addr,
    output tomasulo_pkg::data_t         rd_data
);

    logic [tomasulo_pkg::NUM_STATIONS-1:0] load_en;
    logic [tomasulo_pkg::NUM_STATIONS-1:0] dispatch_en;
    tomasulo_pkg::ctl_word                 load_word;
    tomasulo_pkg::ctl_word                 stations [tomasulo_pkg::NUM_STATIONS];
    logic                                  rename_en;
    tomasulo_pkg::reg_idx_t                rename_rd;
    tomasulo_pkg::tag_t                    rename_tag;
    tomasulo_pkg::reg_idx_t                look_rs1;
    tomasulo_pkg::reg_idx_t                look_rs2;
    tomasulo_pkg::operand_t                look1;
    tomasulo_pkg::operand_t                look2;

    ctl_word_bank i_ctl_word_bank (
        .clk         (clk),
        .rst1        (rst1),
        .load_en     (load_en),
        .load_word   (load_word),
        .dispatch_en (dispatch_en),
        .cdb         (cdb),
        .stations    (stations)
    );

    reg_status i_reg_status (
        .clk        (clk),
        .rst1       (rst1),
        .rename_en  (rename_en),
        .rename_rd  (rename_rd),
        .rename_tag (rename_tag),
        .cdb        (cdb),
        .look_rs1   (look_rs1),
        .look_rs2   (look_rs2),
        .look1      (look1),
        .look2      (look2),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    issue_ctl i_issue_ctl (
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .stations    (stations),
        .cdb         (cdb),
        .look1       (look1),
        .look2       (look2),
        .look_rs1    (look_rs1),
        .look_rs2    (look_rs2),
        .load_en     (load_en),
        .load_word   (load_word),
        .rename_en   (rename_en),
        .rename_rd   (rename_rd),
        .rename_tag  (rename_tag),
        .issue_stall (issue_stall)
    );

    exec_pipe i_exec_pipe (
        .clk         (clk),
        .rst1        (rst1),
        .stations    (stations),
        .dispatch_en (dispatch_en),
        .cdb         (cdb)
    );

endmodule

`default_nettype wire

//--- hdl/tomasulo_pkg.sv
// Tomasulo core shared widths, opcodes, station and CDB types, and the CDB snoop helper.
`default_nettype none

package tomasulo_pkg;

    localparam int NUM_STATIONS = 8;
    localparam int NUM_REGS     = 8;

    typedef logic [15:0] data_t;
    typedef logic [2:0]  reg_idx_t;
    typedef logic [2:0]  tag_t;
    typedef logic [7:0]  imm_t;

    typedef enum logic [2:0] {
        OP_ADD   = 3'd0,
        OP_SUB   = 3'd1,
        OP_AND   = 3'd2,
        OP_XOR   = 3'd3,
        OP_LOADI = 3'd4
    } op_e;

    typedef struct packed {
        op_e      op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        imm_t     imm;
    } instr_t;

    // One source of a station; tag is only meaningful while not ready.
    typedef struct packed {
        logic  ready;
        tag_t  tag;
        data_t value;
    } operand_t;

    typedef struct packed {
        logic     busy;
        logic     issued;
        op_e      op;
        operand_t src1;
        operand_t src2;
    } ctl_word;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        data_t value;
    } cdb_t;

    // Capture a waiting operand when its producer is on the bus.
    function automatic operand_t snoop(operand_t src, cdb_t bus);
        operand_t res;
        res = src;
        if (!src.ready && bus.valid && bus.tag == src.tag) begin
            res.ready = 1'b1;
            res.value = bus.value;
        end
        return res;
    endfunction

endpackage

`default_nettype wire

//--- vlog.f
hdl/tomasulo_pkg.sv
hdl/ctl_word_bank.sv
hdl/reg_status.sv
hdl/issue_ctl.sv
hdl/exec_pipe.sv
hdl/tomasulo_core.sv
dv/tomasulo_checker.sv
dv/tomasulo_monitor.sv
dv/tb_tomasulo.sv
